//--- Makefile
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_cmd_rx_top: verilog.f $(SRCS)
	verilator --binary --timing --top-module tb_cmd_rx_top -f verilog.f

run: obj_dir/Vtb_cmd_rx_top
	@out="$$(./obj_dir/Vtb_cmd_rx_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

//--- cmd_capture.sv
module cmd_capture #(
    parameter int CMD_DEPTH = 16
) (
    input  logic                   gmii_rxc,
    input  logic                   rst,
    input  eth_pkg::payload_byte_t payload,
    input  logic                   fs_udp_rx,
    input  logic                   fd_udp_rx,
    input  logic                   fe_udp_rx,
    output cmd_pkg::cmd_write_t    wr,
    output logic                   wr_en,
    output logic                   frame_commit,
    output logic                   overflow
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    cmd_pkg::cmd_write_t pair_mem [CMD_DEPTH];

    logic [7:0]       idx_q;
    logic [CNT_W-1:0] pair_cnt;
    logic [CNT_W-1:0] rd_ptr;
    logic             dropped;
    logic             replaying;
    logic             rd_last;
    logic             pair_done;
    logic             has_room;

    // Odd offset closes a pair started by the preceding even byte
    assign pair_done = payload.valid && payload.offset[0];
    assign has_room  = (pair_cnt < CNT_W'(CMD_DEPTH));
    assign rd_last   = (pair_cnt == '0) || (rd_ptr == pair_cnt - 1'b1);

    assign wr           = pair_mem[rd_ptr[PTR_W-1:0]];
    assign wr_en        = replaying && (pair_cnt != '0);
    assign frame_commit = replaying && rd_last;
    assign overflow     = frame_commit && dropped;

    always_ff @(posedge gmii_rxc) begin
        if (payload.valid && !payload.offset[0]) begin
            idx_q <= payload.data;
        end
        if (pair_done && has_room) begin
            pair_mem[pair_cnt[PTR_W-1:0]] <= '{index: idx_q, value: payload.data};
        end
    end

    always_ff @(posedge gmii_rxc) begin
        if (rst) begin
            pair_cnt  <= '0;
            rd_ptr    <= '0;
            dropped   <= 1'b0;
            replaying <= 1'b0;
        end else if (replaying) begin
            rd_ptr <= rd_ptr + 1'b1;
            if (rd_last) begin
                replaying <= 1'b0;
                pair_cnt  <= '0;
                dropped   <= 1'b0;
            end
        end else if (fs_udp_rx || fe_udp_rx) begin
            // New frame or aborted one, start over
            pair_cnt <= '0;
            dropped  <= 1'b0;
        end else if (fd_udp_rx) begin
            replaying <= 1'b1;
            rd_ptr    <= '0;
        end else if (pair_done) begin
            if (has_room) begin
                pair_cnt <= pair_cnt + 1'b1;
            end else begin
                dropped <= 1'b1;
            end
        end
    end

endmodule

//--- cmd_pkg.sv
package cmd_pkg;

    localparam int NUM_CMD_REGS = 9;

    // Register index as carried in the payload
    localparam logic [7:0] IDX_KDEV = 8'd0;
    localparam logic [7:0] IDX_SMPR = 8'd1;
    localparam logic [7:0] IDX_FILT = 8'd2;
    localparam logic [7:0] IDX_MIX0 = 8'd3;
    localparam logic [7:0] IDX_MIX1 = 8'd4;
    localparam logic [7:0] IDX_REG4 = 8'd5;
    localparam logic [7:0] IDX_REG5 = 8'd6;
    localparam logic [7:0] IDX_REG6 = 8'd7;
    localparam logic [7:0] IDX_REG7 = 8'd8;

    typedef struct packed {
        logic [7:0] index;
        logic [7:0] value;
    } cmd_write_t;

    typedef struct packed {
        logic [7:0] kdev;
        logic [7:0] smpr;
        logic [7:0] filt;
        logic [7:0] mix0;
        logic [7:0] mix1;
        logic [7:0] reg4;
        logic [7:0] reg5;
        logic [7:0] reg6;
        logic [7:0] reg7;
    } cmd_regs_t;

endpackage

//--- cmd_regfile.sv
module cmd_regfile (
    input  logic                gmii_rxc,
    input  logic                rst,
    input  cmd_pkg::cmd_write_t wr,
    input  logic                wr_en,
    input  logic                frame_commit,
    input  logic                overflow,
    output cmd_pkg::cmd_regs_t  cmd_regs,
    output logic [3:0]          led,
    output logic                lec
);

    logic bad_index;

    assign bad_index = wr_en && (wr.index >= 8'(cmd_pkg::NUM_CMD_REGS));

    always_ff @(posedge gmii_rxc) begin
        if (rst) begin
            cmd_regs <= '0;
            led      <= 4'd0;
            lec      <= 1'b0;
        end else begin
            if (wr_en) begin
                case (wr.index)
                    cmd_pkg::IDX_KDEV: cmd_regs.kdev <= wr.value;
                    cmd_pkg::IDX_SMPR: cmd_regs.smpr <= wr.value;
                    cmd_pkg::IDX_FILT: cmd_regs.filt <= wr.value;
                    cmd_pkg::IDX_MIX0: cmd_regs.mix0 <= wr.value;
                    cmd_pkg::IDX_MIX1: cmd_regs.mix1 <= wr.value;
                    cmd_pkg::IDX_REG4: cmd_regs.reg4 <= wr.value;
                    cmd_pkg::IDX_REG5: cmd_regs.reg5 <= wr.value;
                    cmd_pkg::IDX_REG6: cmd_regs.reg6 <= wr.value;
                    cmd_pkg::IDX_REG7: cmd_regs.reg7 <= wr.value;
                    default: ;
                endcase
            end
            // Frame counter wraps at 16
            if (frame_commit) begin
                led <= led + 4'd1;
            end
            // Error lamp is sticky until reset
            if (bad_index || overflow) begin
                lec <= 1'b1;
            end
        end
    end

endmodule

//--- cmd_rx_golden.txt
# frame <byte count, decimal> then the bytes from preamble through payload, hex
# expect kdev smpr filt mix0 mix1 reg4 reg5 reg6 reg7 led lec, hex; reset pulses rst
frame 62 55 55 55 55 55 55 55 d5 00 0a 35 01 fe c0 00 11 22 33 44 55 08 00
45 00 00 28 00 01 00 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02 04 00 1f 90 00 14 00 00
00 12 01 34 02 56 05 9a 00 ab 08 7f
expect ab 34 56 00 00 9a 00 00 7f 1 0
# wrong destination MAC, IP, port, ethertype and protocol
frame 54 55 55 55 55 55 55 55 d5 00 0a 35 01 fe c1 00 11 22 33 44 55 08 00
45 00 00 20 00 02 00 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02 04 00 1f 90 00 0c 00 00 03 11 04 22
expect ab 34 56 00 00 9a 00 00 7f 1 0
frame 54 55 55 55 55 55 55 55 d5 00 0a 35 01 fe c0 00 11 22 33 44 55 08 00
45 00 00 20 00 03 00 00 40 11 00 00 c0 a8 00 01 c0 a8 00 03 04 00 1f 90 00 0c 00 00 03 11 04 22
expect ab 34 56 00 00 9a 00 00 7f 1 0
frame 54 55 55 55 55 55 55 55 d5 00 0a 35 01 fe c0 00 11 22 33 44 55 08 00
45 00 00 20 00 04 00 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02 04 00 1f 91 00 0c 00 00 03 11 04 22
expect ab 34 56 00 00 9a 00 00 7f 1 0
frame 54 55 55 55 55 55 55 55 d5 00 0a 35 01 fe c0 00 11 22 33 44 55 86 dd
45 00 00 20 00 05 00 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02 04 00 1f 90 00 0c 00 00 03 11 04 22
expect ab 34 56 00 00 9a 00 00 7f 1 0
frame 54 55 55 55 55 55 55 55 d5 00 0a 35 01 fe c0 00 11 22 33 44 55 08 00
45 00 00 20 00 06 00 00 40 06 00 00 c0 a8 00 01 c0 a8 00 02 04 00 1f 90 00 0c 00 00 03 11 04 22
expect ab 34 56 00 00 9a 00 00 7f 1 0
# payload cut after 5 of 12 bytes
frame 55 55 55 55 55 55 55 55 d5 00 0a 35 01 fe c0 00 11 22 33 44 55 08 00
45 00 00 28 00 07 00 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02 04 00 1f 90 00 14 00 00
01 ee 02 ee 06
expect ab 34 56 00 00 9a 00 00 7f 1 0
# 17 pairs plus a lone byte
frame 85 55 55 55 55 55 55 55 d5 00 0a 35 01 fe c0 00 11 22 33 44 55 08 00
45 00 00 3f 00 08 00 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02 04 00 1f 90 00 2b 00 00
06 01 06 02 06 03 06 04 06 05 06 06 06 07 06 08 06 09
06 0a 06 0b 06 0c 06 0d 06 0e 06 0f 06 10 06 ff 07
expect ab 34 56 00 00 9a 10 00 7f 2 1
reset
expect 00 00 00 00 00 00 00 00 00 0 0
# out-of-range indices next to valid pairs
frame 59 55 55 55 55 55 55 55 d5 00 0a 35 01 fe c0 00 11 22 33 44 55 08 00
45 00 00 25 00 09 00 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02 04 00 1f 90 00 11 00 00
01 5a 09 33 07 c3 ff 01 03
expect 00 5a 00 00 00 00 00 c3 00 1 1
frame 52 55 55 55 55 55 55 55 d5 00 0a 35 01 fe c0 00 11 22 33 44 55 08 00
45 00 00 1e 00 0a 00 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02 04 00 1f 90 00 0a 00 00 02 44
expect 00 5a 44 00 00 00 00 c3 00 2 1

//--- cmd_rx_top.sv
module cmd_rx_top #(
    parameter eth_pkg::net_addr_t NODE_ADDR = '{
        mac:  48'h00_0A_35_01_FE_C0,
        ip:   32'hC0_A8_00_02,
        port: 16'h1F90
    },
    parameter int CMD_DEPTH = 16
) (
    input  logic               gmii_rxc,
    input  logic               rst,
    input  logic               mac_rxdv,
    input  logic [7:0]         mac_rxd,
    output cmd_pkg::cmd_regs_t cmd_regs,
    output logic [3:0]         led,
    output logic               lec
);

    eth_pkg::payload_byte_t payload;
    logic                   fs_udp_rx;
    logic                   fd_udp_rx;
    logic                   fe_udp_rx;

    cmd_pkg::cmd_write_t    wr;
    logic                   wr_en;
    logic                   frame_commit;
    logic                   overflow;

    udp_rx #(
        .NODE_ADDR(NODE_ADDR)
    ) i_udp_rx (
        .gmii_rxc(gmii_rxc),
        .rst(rst),
        .mac_rxdv(mac_rxdv),
        .mac_rxd(mac_rxd),
        .payload(payload),
        .fs_udp_rx(fs_udp_rx),
        .fd_udp_rx(fd_udp_rx),
        .fe_udp_rx(fe_udp_rx),
        .udp_rx_len()
    );

    cmd_capture #(
        .CMD_DEPTH(CMD_DEPTH)
    ) i_cmd_capture (
        .gmii_rxc(gmii_rxc),
        .rst(rst),
        .payload(payload),
        .fs_udp_rx(fs_udp_rx),
        .fd_udp_rx(fd_udp_rx),
        .fe_udp_rx(fe_udp_rx),
        .wr(wr),
        .wr_en(wr_en),
        .frame_commit(frame_commit),
        .overflow(overflow)
    );

    cmd_regfile i_cmd_regfile (
        .gmii_rxc(gmii_rxc),
        .rst(rst),
        .wr(wr),
        .wr_en(wr_en),
        .frame_commit(frame_commit),
        .overflow(overflow),
        .cmd_regs(cmd_regs),
        .led(led),
        .lec(lec)
    );

endmodule

//--- eth_pkg.sv
package eth_pkg;

    // Receive stream framing
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE = 8'hd5;

    // Header field values
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0] IP_PROTO_UDP = 8'h11;

    // MAC 14 + IP 20 + UDP 8, counted from the byte after the SFD
    localparam int HEADER_LEN = 42;
    localparam int UDP_HDR_LEN = 8;

    // Node address as seen in the destination fields
    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [15:0] port;
    } net_addr_t;

    // One UDP payload byte with its position in the payload
    typedef struct packed {
        logic        valid;
        logic [7:0]  data;
        logic [10:0] offset;
    } payload_byte_t;

endpackage

//--- tb_cmd_rx_top.sv
module tb_cmd_rx_top;

    localparam int CMD_DEPTH = 16;
    localparam int MAX_RECORDS = 200;

    logic               gmii_rxc;
    logic               rst;
    logic               mac_rxdv;
    logic [7:0]         mac_rxd;
    cmd_pkg::cmd_regs_t cmd_regs;
    logic [3:0]         led;
    logic               lec;

    int fd;

    cmd_rx_top i_cmd_rx_top (
        .gmii_rxc(gmii_rxc),
        .rst(rst),
        .mac_rxdv(mac_rxdv),
        .mac_rxd(mac_rxd),
        .cmd_regs(cmd_regs),
        .led(led),
        .lec(lec)
    );

    initial begin
        gmii_rxc = 1'b0;
        forever #4 gmii_rxc = ~gmii_rxc;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("FAILED %s expected 0x%0h actual 0x%0h",
                                        name, expected, actual));
        end
    endtask

    // Inputs change 1 time unit after the rising edge
    task automatic next_edge();
        @(posedge gmii_rxc);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            next_edge();
        end
    endtask

    task automatic apply_reset();
        rst      = 1'b1;
        mac_rxdv = 1'b0;
        mac_rxd  = 8'h00;
        idle_cycles(3);
        rst = 1'b0;
    endtask

    task automatic send_frame(input int count);
        logic [7:0] b;
        int         code;
        for (int i = 0; i < count; i++) begin
            code = $fscanf(fd, "%h", b);
            if (code != 1) begin
                stop_with_failure("Could not read a frame byte from the golden file");
            end
            next_edge();
            mac_rxdv = 1'b1;
            mac_rxd  = b;
        end
        next_edge();
        mac_rxdv = 1'b0;
        mac_rxd  = 8'h00;
        // Registers and led settle within this bound after the last byte
        idle_cycles(CMD_DEPTH + 4);
    endtask

    task automatic check_expect();
        logic [7:0] v [11];
        int         code;
        for (int i = 0; i < 11; i++) begin
            code = $fscanf(fd, "%h", v[i]);
            if (code != 1) begin
                stop_with_failure("Could not read an expected value from the golden file");
            end
        end
        check_value("kdev", 32'(v[0]), 32'(cmd_regs.kdev));
        check_value("smpr", 32'(v[1]), 32'(cmd_regs.smpr));
        check_value("filt", 32'(v[2]), 32'(cmd_regs.filt));
        check_value("mix0", 32'(v[3]), 32'(cmd_regs.mix0));
        check_value("mix1", 32'(v[4]), 32'(cmd_regs.mix1));
        check_value("reg4", 32'(v[5]), 32'(cmd_regs.reg4));
        check_value("reg5", 32'(v[6]), 32'(cmd_regs.reg5));
        check_value("reg6", 32'(v[7]), 32'(cmd_regs.reg6));
        check_value("reg7", 32'(v[8]), 32'(cmd_regs.reg7));
        check_value("led", 32'(v[9]), 32'(led));
        check_value("lec", 32'(v[10]), 32'(lec));
    endtask

    initial begin
        logic [63:0]  tok;
        logic [799:0] rest;
        int           code;
        int           count;
        int           records;
        bit           done;
        rst      = 1'b1;
        mac_rxdv = 1'b0;
        mac_rxd  = 8'h00;
        records  = 0;
        done     = 1'b0;
        void'($urandom(32'h72e4));
        fd = $fopen("cmd_rx_golden.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open cmd_rx_golden.txt for reading");
        end
        apply_reset();
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok == 64'("#")) begin
                code = $fgets(rest, fd);
            end else begin
                records++;
                if (records > MAX_RECORDS) begin
                    stop_with_failure("Golden file holds more records than allowed");
                end
                if (tok == 64'("frame")) begin
                    code = $fscanf(fd, "%d", count);
                    if (code != 1 || count < 1) begin
                        stop_with_failure("Bad byte count in a frame record");
                    end
                    send_frame(count);
                end else if (tok == 64'("expect")) begin
                    check_expect();
                    // Random interframe gap
                    idle_cycles(12 + int'($urandom % 19));
                end else if (tok == 64'("reset")) begin
                    apply_reset();
                end else begin
                    stop_with_failure("Unknown record type in the golden file");
                end
            end
        end
        $fclose(fd);
        if (records > 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_with_failure("Golden file held no records");
        end
    end

endmodule

//--- udp_rx.sv
module udp_rx #(
    parameter eth_pkg::net_addr_t NODE_ADDR = '0
) (
    input  logic                   gmii_rxc,
    input  logic                   rst,
    input  logic                   mac_rxdv,
    input  logic [7:0]             mac_rxd,
    output eth_pkg::payload_byte_t payload,
    output logic                   fs_udp_rx,
    output logic                   fd_udp_rx,
    output logic                   fe_udp_rx,
    output logic [15:0]            udp_rx_len
);

    // UDP length field sits 4 bytes before the end of the header
    localparam logic [5:0] LEN_HI_POS = 6'(eth_pkg::HEADER_LEN - 4);
    localparam logic [5:0] LEN_LO_POS = 6'(eth_pkg::HEADER_LEN - 3);
    localparam logic [5:0] HDR_LAST_POS = 6'(eth_pkg::HEADER_LEN - 1);

    typedef enum logic [1:0] {
        ST_HUNT,
        ST_HEADER,
        ST_PAYLOAD,
        ST_WAIT
    } state_t;

    state_t      state;
    logic [5:0]  hdr_cnt;
    logic [15:0] pay_cnt;
    logic [15:0] pay_len;
    logic [7:0]  exp_byte;
    logic        chk_en;
    logic        pay_last;
    logic        fd_pend;
    logic        pay_valid;
    logic [7:0]  pay_data;
    logic [10:0] pay_off;

    assign pay_len  = udp_rx_len - 16'(eth_pkg::UDP_HDR_LEN);
    assign pay_last = (pay_cnt == pay_len - 16'd1);
    assign payload  = '{valid: pay_valid, data: pay_data, offset: pay_off};

    // Expected byte per header offset; unchecked fields pass through
    always_comb begin
        chk_en   = 1'b1;
        exp_byte = 8'h00;
        case (hdr_cnt) inside
            [6'd0:6'd5]:
                exp_byte = NODE_ADDR.mac[8 * (6'd5 - hdr_cnt) +: 8];
            [6'd12:6'd13]:
                exp_byte = hdr_cnt[0] ? eth_pkg::ETHERTYPE_IPV4[7:0]
                                      : eth_pkg::ETHERTYPE_IPV4[15:8];
            6'd23:
                exp_byte = eth_pkg::IP_PROTO_UDP;
            [6'd30:6'd33]:
                exp_byte = NODE_ADDR.ip[8 * (6'd33 - hdr_cnt) +: 8];
            [6'd36:6'd37]:
                exp_byte = NODE_ADDR.port[8 * (6'd37 - hdr_cnt) +: 8];
            default:
                chk_en = 1'b0;
        endcase
    end

    always_ff @(posedge gmii_rxc) begin
        if (rst) begin
            state     <= ST_HUNT;
            hdr_cnt   <= '0;
            pay_cnt   <= '0;
            pay_valid <= 1'b0;
            fs_udp_rx <= 1'b0;
            fe_udp_rx <= 1'b0;
            fd_pend   <= 1'b0;
            fd_udp_rx <= 1'b0;
        end else begin
            pay_valid <= 1'b0;
            fs_udp_rx <= 1'b0;
            fe_udp_rx <= 1'b0;
            fd_pend   <= 1'b0;
            fd_udp_rx <= fd_pend;
            case (state)
                ST_HUNT: begin
                    hdr_cnt <= '0;
                    if (mac_rxdv) begin
                        if (mac_rxd == eth_pkg::SFD_BYTE) begin
                            state <= ST_HEADER;
                        end else if (mac_rxd != eth_pkg::PREAMBLE_BYTE) begin
                            state <= ST_WAIT;
                        end
                    end
                end
                ST_HEADER: begin
                    hdr_cnt <= hdr_cnt + 6'd1;
                    pay_cnt <= '0;
                    if (!mac_rxdv) begin
                        state <= ST_HUNT;
                    end else if (chk_en && mac_rxd != exp_byte) begin
                        state <= ST_WAIT;
                    end else if (hdr_cnt == HDR_LAST_POS) begin
                        if (udp_rx_len > 16'(eth_pkg::UDP_HDR_LEN)) begin
                            state <= ST_PAYLOAD;
                        end else begin
                            // Empty payload still completes the frame
                            fd_pend <= 1'b1;
                            state   <= ST_WAIT;
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (!mac_rxdv) begin
                        fe_udp_rx <= 1'b1;
                        state     <= ST_HUNT;
                    end else begin
                        pay_valid <= 1'b1;
                        fs_udp_rx <= (pay_cnt == 16'd0);
                        pay_cnt   <= pay_cnt + 16'd1;
                        if (pay_last) begin
                            fd_pend <= 1'b1;
                            state   <= ST_WAIT;
                        end
                    end
                end
                default: begin
                    if (!mac_rxdv) begin
                        state <= ST_HUNT;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge gmii_rxc) begin
        pay_data <= mac_rxd;
        pay_off  <= pay_cnt[10:0];
        if (state == ST_HEADER && hdr_cnt == LEN_HI_POS) begin
            udp_rx_len[15:8] <= mac_rxd;
        end
        if (state == ST_HEADER && hdr_cnt == LEN_LO_POS) begin
            udp_rx_len[7:0] <= mac_rxd;
        end
    end

endmodule

//--- verilog.f
eth_pkg.sv
cmd_pkg.sv
udp_rx.sv
cmd_capture.sv
cmd_regfile.sv
cmd_rx_top.sv
tb_cmd_rx_top.sv
